//--- fetch_top.f
rtl/fetch_pkg.sv
rtl/pc_fetch_unit.sv
rtl/icache.sv
rtl/mem_arbiter.sv
rtl/main_memory.sv
rtl/fetch_top.sv
tests/fetch_top_tb.sv

//--- rtl/fetch_pkg.sv
// fetch package: shared widths, line type, memory opcode and fsm state encodings
package fetch_pkg;

    // address and pc width
    localparam int XLEN = 64;

    // one instruction word
    localparam int INSTR_W = 32;

    // cache line and memory word, four instructions
    localparam int LINE_W = 128;

    // cycles from a sampled memory request to memory ready
    localparam int MEM_LATENCY = 2;

    typedef logic [LINE_W-1:0] line_t;

    // memory access type, one bit on the wire
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // icache refill fsm
    typedef enum logic [1:0] {
        IC_IDLE      = 2'd0,
        IC_LOOKUP    = 2'd1,
        IC_REFILL    = 2'd2,
        IC_FILL_WAIT = 2'd3
    } icache_state_e;

    // memory grant owner
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_IC   = 2'd1,
        ARB_DP   = 2'd2
    } arb_state_e;

endpackage

//--- rtl/fetch_top.sv
// fetch top: fetch unit, icache, memory arbiter and main memory with an external data port
module fetch_top #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC  = 64'h80000000,
    parameter int                         IC_SETS   = 16,
    parameter int                         MEM_LINES = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    // fetch control
    input  logic                          dnpc_valid_i,
    input  logic                          block_i,
    input  logic [fetch_pkg::XLEN-1:0]    dnpc_i,
    output logic [fetch_pkg::XLEN-1:0]    pc_o,
    output logic [fetch_pkg::INSTR_W-1:0] instr_o,
    output logic                          instr_valid_o,
    // line data port
    input  logic                          dp_req_i,
    input  fetch_pkg::mem_op_e            dp_op_i,
    input  logic [fetch_pkg::XLEN-1:0]    dp_addr_i,
    input  fetch_pkg::line_t              dp_wdata_i,
    output fetch_pkg::line_t              dp_rdata_o,
    output logic                          dp_ready_o
);
    import fetch_pkg::*;

    localparam int MA_W = $clog2(MEM_LINES);

    // fetch unit to icache
    logic              cpu_req;
    logic [63:0]       cpu_rdata;
    logic              cpu_ready;

    // icache refill to arbiter
    logic              ic_req;
    logic [XLEN-1:0]   ic_addr;
    line_t             ic_rdata;
    logic              ic_ready;

    // arbiter to memory
    logic              mem_req;
    mem_op_e           mem_op;
    logic [MA_W-1:0]   mem_addr;
    line_t             mem_wdata;
    line_t             mem_rdata;
    logic              mem_ready;

    pc_fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_i (
        .clk           (clk),
        .rst           (rst),
        .dnpc_valid_i  (dnpc_valid_i),
        .block_i       (block_i),
        .dnpc_i        (dnpc_i),
        .pc_o          (pc_o),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .cpu_req_o     (cpu_req),
        .cpu_rdata_i   (cpu_rdata),
        .cpu_ready_i   (cpu_ready)
    );

    // the cache latches the pc itself on cpu_req
    icache #(
        .IC_SETS (IC_SETS)
    ) icache_i (
        .clk         (clk),
        .rst         (rst),
        .cpu_addr_i  (pc_o),
        .cpu_req_i   (cpu_req),
        .cpu_rdata_o (cpu_rdata),
        .cpu_ready_o (cpu_ready),
        .mem_req_o   (ic_req),
        .mem_addr_o  (ic_addr),
        .mem_rdata_i (ic_rdata),
        .mem_ready_i (ic_ready)
    );

    mem_arbiter #(
        .MEM_LINES (MEM_LINES)
    ) arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .ic_req_i    (ic_req),
        .ic_addr_i   (ic_addr),
        .ic_rdata_o  (ic_rdata),
        .ic_ready_o  (ic_ready),
        .dp_req_i    (dp_req_i),
        .dp_op_i     (dp_op_i),
        .dp_addr_i   (dp_addr_i),
        .dp_wdata_i  (dp_wdata_i),
        .dp_rdata_o  (dp_rdata_o),
        .dp_ready_o  (dp_ready_o),
        .mem_req_o   (mem_req),
        .mem_op_o    (mem_op),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .mem_ready_i (mem_ready)
    );

    main_memory #(
        .MEM_LINES (MEM_LINES)
    ) memory_i (
        .clk     (clk),
        .rst     (rst),
        .req_i   (mem_req),
        .op_i    (mem_op),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata),
        .ready_o (mem_ready)
    );

endmodule

//--- rtl/icache.sv
// direct-mapped instruction cache, 128-bit lines, refilled from the memory arbiter
module icache #(
    parameter int IC_SETS = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [fetch_pkg::XLEN-1:0] cpu_addr_i,
    input  logic                       cpu_req_i,
    output logic [63:0]                cpu_rdata_o,
    output logic                       cpu_ready_o,
    output logic                       mem_req_o,
    output logic [fetch_pkg::XLEN-1:0] mem_addr_o,
    input  fetch_pkg::line_t           mem_rdata_i,
    input  logic                       mem_ready_i
);
    import fetch_pkg::*;

    // 16 bytes per line, so bits [3:0] are the offset
    localparam int IDX_W = $clog2(IC_SETS);
    localparam int TAG_W = XLEN - 4 - IDX_W;

    icache_state_e state_q;

    // request address split into line address and 64-bit half
    logic [XLEN-1:4]   line_addr_q;
    logic              half_q;
    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;

    // tag, valid and data arrays
    logic [TAG_W-1:0]  tag_q [IC_SETS];
    logic [IC_SETS-1:0] valid_q;
    line_t             data_q [IC_SETS];

    line_t             line_sel;
    logic [63:0]       half_sel;
    logic              hit;

    assign idx = line_addr_q[IDX_W+3:4];
    assign tag = line_addr_q[XLEN-1:IDX_W+4];

    assign line_sel = data_q[idx];
    assign half_sel = half_q ? line_sel[LINE_W-1:64] : line_sel[63:0];
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);

    // refill request held for the whole REFILL state, line aligned
    assign mem_req_o  = (state_q == IC_REFILL);
    assign mem_addr_o = {line_addr_q, 4'b0000};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= IC_IDLE;
            valid_q     <= '0;
            cpu_ready_o <= 1'b0;
        end else begin
            cpu_ready_o <= 1'b0;
            case (state_q)
                IC_IDLE: begin
                    if (cpu_req_i) begin
                        state_q <= IC_LOOKUP;
                    end
                end
                IC_LOOKUP: begin
                    // hit answers two cycles after the request
                    if (hit) begin
                        cpu_ready_o <= 1'b1;
                        state_q     <= IC_IDLE;
                    end else begin
                        state_q <= IC_REFILL;
                    end
                end
                IC_REFILL: begin
                    if (mem_ready_i) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= IC_FILL_WAIT;
                    end
                end
                IC_FILL_WAIT: begin
                    // line is in the array now, answer from it
                    cpu_ready_o <= 1'b1;
                    state_q     <= IC_IDLE;
                end
                default: begin
                    state_q <= IC_IDLE;
                end
            endcase
        end
    end

    // address latch, arrays and read data carry no reset
    always_ff @(posedge clk) begin
        if (state_q == IC_IDLE && cpu_req_i) begin
            line_addr_q <= cpu_addr_i[XLEN-1:4];
            half_q      <= cpu_addr_i[3];
        end
        if (state_q == IC_REFILL && mem_ready_i) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= mem_rdata_i;
        end
        if ((state_q == IC_LOOKUP && hit) || state_q == IC_FILL_WAIT) begin
            cpu_rdata_o <= half_sel;
        end
    end

    // refill request may not drop or move before the memory answers
    a_refill_held: assert property (@(posedge clk) disable iff (rst)
        (mem_req_o && !mem_ready_i) |=> (mem_req_o && $stable(mem_addr_o)))
        else $error("refill request dropped or address changed before ready");

endmodule

//--- rtl/main_memory.sv
// line-wide main memory, fixed latency, one access at a time
module main_memory #(
    parameter  int MEM_LINES = 256,
    localparam int ADDR_W    = $clog2(MEM_LINES)
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_i,
    input  fetch_pkg::mem_op_e op_i,
    input  logic [ADDR_W-1:0]  addr_i,
    input  fetch_pkg::line_t   wdata_i,
    output fetch_pkg::line_t   rdata_o,
    output logic               ready_o
);
    import fetch_pkg::*;

    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    // storage survives reset
    line_t             mem_q [MEM_LINES];

    logic              busy_q;
    logic [CNT_W-1:0]  cnt_q;

    // access captured when the request is sampled
    mem_op_e           op_q;
    logic [ADDR_W-1:0] addr_q;
    line_t             wdata_q;

    // countdown hits zero exactly MEM_LATENCY cycles after the request
    assign ready_o = busy_q && (cnt_q == '0);
    assign rdata_o = mem_q[addr_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (!busy_q) begin
            if (req_i) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(MEM_LATENCY - 1);
            end
        end else if (ready_o) begin
            // request still high in the ready cycle is the finished one
            busy_q <= 1'b0;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_q && req_i) begin
            op_q    <= op_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
        // write lands on the ready edge
        if (ready_o && op_q == MEM_WRITE) begin
            mem_q[addr_q] <= wdata_q;
        end
    end

endmodule

//--- rtl/mem_arbiter.sv
// memory arbiter: icache refill has priority over the data port, grant held until ready
module mem_arbiter #(
    parameter  int MEM_LINES = 256,
    localparam int MA_W      = $clog2(MEM_LINES)
) (
    input  logic                       clk,
    input  logic                       rst,
    // icache refill side, read only
    input  logic                       ic_req_i,
    input  logic [fetch_pkg::XLEN-1:0] ic_addr_i,
    output fetch_pkg::line_t           ic_rdata_o,
    output logic                       ic_ready_o,
    // external data port
    input  logic                       dp_req_i,
    input  fetch_pkg::mem_op_e         dp_op_i,
    input  logic [fetch_pkg::XLEN-1:0] dp_addr_i,
    input  fetch_pkg::line_t           dp_wdata_i,
    output fetch_pkg::line_t           dp_rdata_o,
    output logic                       dp_ready_o,
    // shared memory
    output logic                       mem_req_o,
    output fetch_pkg::mem_op_e         mem_op_o,
    output logic [MA_W-1:0]            mem_addr_o,
    output fetch_pkg::line_t           mem_wdata_o,
    input  fetch_pkg::line_t           mem_rdata_i,
    input  logic                       mem_ready_i
);
    import fetch_pkg::*;

    arb_state_e state_q;

    // grant takes a cycle, so the request reaches memory one cycle after it is raised
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ARB_IDLE;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    // fixed priority, icache first
                    if (ic_req_i) begin
                        state_q <= ARB_IC;
                    end else if (dp_req_i) begin
                        state_q <= ARB_DP;
                    end
                end
                ARB_IC, ARB_DP: begin
                    if (mem_ready_i) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: begin
                    state_q <= ARB_IDLE;
                end
            endcase
        end
    end

    assign mem_req_o = (state_q != ARB_IDLE);

    // byte address to line index, icache side only ever reads
    assign mem_op_o    = (state_q == ARB_DP) ? dp_op_i : MEM_READ;
    assign mem_addr_o  = (state_q == ARB_DP) ? dp_addr_i[4 +: MA_W] : ic_addr_i[4 +: MA_W];
    assign mem_wdata_o = dp_wdata_i;

    // read data fans out, ready only to the owner
    assign ic_rdata_o = mem_rdata_i;
    assign dp_rdata_o = mem_rdata_i;
    assign ic_ready_o = (state_q == ARB_IC) && mem_ready_i;
    assign dp_ready_o = (state_q == ARB_DP) && mem_ready_i;

    a_single_ready: assert property (@(posedge clk) disable iff (rst)
        !(ic_ready_o && dp_ready_o))
        else $error("icache and data port ready together");

    // memory only finishes an access this arbiter granted
    a_ready_granted: assert property (@(posedge clk) disable iff (rst)
        mem_ready_i |-> (state_q != ARB_IDLE))
        else $error("memory ready with no grant");

endmodule

//--- rtl/pc_fetch_unit.sv
// fetch unit: holds the pc, issues one cache request per pc update and selects the word
module pc_fetch_unit #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = 64'h80000000
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dnpc_valid_i,
    input  logic                          block_i,
    input  logic [fetch_pkg::XLEN-1:0]    dnpc_i,
    output logic [fetch_pkg::XLEN-1:0]    pc_o,
    output logic [fetch_pkg::INSTR_W-1:0] instr_o,
    output logic                          instr_valid_o,
    output logic                          cpu_req_o,
    input  logic [63:0]                   cpu_rdata_i,
    input  logic                          cpu_ready_i
);
    import fetch_pkg::*;

    logic [XLEN-1:0]    pc_q;
    logic               pc_en;
    // a pc update still waiting for its cache request
    logic               pending_q;
    // one fetch in flight, between request and ready
    logic               busy_q;
    // pc[2] of the fetch in flight, picks the word out of the 64-bit half
    logic               word_sel_q;
    logic [INSTR_W-1:0] instr_q;
    logic               instr_valid_q;

    // block freezes the pc
    assign pc_en = dnpc_valid_i & ~block_i;

    // request only when nothing is outstanding and not stalled
    assign cpu_req_o = pending_q & ~busy_q & ~block_i;

    assign pc_o          = pc_q;
    assign instr_o       = instr_q;
    assign instr_valid_o = instr_valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q          <= RESET_PC;
            // first fetch from the reset pc goes out without a redirect
            pending_q     <= 1'b1;
            busy_q        <= 1'b0;
            instr_valid_q <= 1'b0;
        end else begin
            if (pc_en) begin
                pc_q <= dnpc_i;
            end
            // a new update keeps the flag even if the old one is issued now
            pending_q <= pc_en | (pending_q & ~cpu_req_o);
            if (cpu_req_o) begin
                busy_q <= 1'b1;
            end else if (cpu_ready_i) begin
                busy_q <= 1'b0;
            end
            // one-cycle pulse, a cycle after the cache answers
            instr_valid_q <= cpu_ready_i;
        end
    end

    // payload, qualified by busy_q and instr_valid_q
    always_ff @(posedge clk) begin
        if (cpu_req_o) begin
            word_sel_q <= pc_q[2];
        end
        if (cpu_ready_i) begin
            instr_q <= word_sel_q ? cpu_rdata_i[INSTR_W +: INSTR_W] : cpu_rdata_i[INSTR_W-1:0];
        end
    end

    // a fetch still in flight next cycle blocks any new request
    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        (busy_q && !cpu_ready_i) |=> !cpu_req_o)
        else $error("cpu_req_o raised while a fetch is outstanding");

    // the cache answers only a request this unit made
    a_ready_has_req: assert property (@(posedge clk) disable iff (rst)
        cpu_ready_i |-> busy_q)
        else $error("cpu_ready_i without an outstanding fetch");

endmodule

//--- run.sh
#!/bin/sh
# build and run the fetch_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    -f fetch_top.f \
    --top-module fetch_top_tb \
    -Mdir "$BUILD_DIR" \
    -o fetch_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/fetch_top_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0

//--- tests/fetch_testdata.txt
// kind address data: 1 line write, 2 fetch (expected word), 3 stalled fetch (block cycles)
// 4 data read (expected line), 5 fetch miss with data read (read address), 6 reset, 0 end
1 80000000 00400213003001930020011300100093
1 80000010 00800413007003930060031300500293
1 80000100 0000006f00b500231050059310000537
1 80000200 02d0069302c0061302b0059302a00513
1 80000340 ffc00893ffd00813ffe00793fff00713
1 80000800 0123456789abcdeffedcba9876543210
6 0 00100093
2 80000004 00200113
2 80000008 00300193
2 8000000c 00400213
2 80000010 00500293
2 80000014 00600313
2 80000104 10500593
2 80000000 00100093
3 80000208 5
1 80000900 cafef00d0badc0de1357924680aceb01
4 80000900 cafef00d0badc0de1357924680aceb01
4 80000800 0123456789abcdeffedcba9876543210
5 8000034c 80000800
0 0 0

//--- tests/fetch_top_tb.sv
// testbench for fetch_top: replays testdata records through the fetch port and the data port
module fetch_top_tb;
    import fetch_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = 64'h80000000;
    localparam int IC_SETS   = 16;
    localparam int MEM_LINES = 256;
    localparam int MA_W      = $clog2(MEM_LINES);
    // every wait gives up after this many cycles
    localparam int TIMEOUT   = 100 * MEM_LATENCY;
    // three tokens per record: kind, address, data
    localparam int MAX_WORDS = 192;

    // record kinds, first column of the testdata file
    localparam int REC_END       = 0;
    localparam int REC_WRITE     = 1;
    localparam int REC_FETCH     = 2;
    localparam int REC_STALL     = 3;
    localparam int REC_READ      = 4;
    localparam int REC_MISS_READ = 5;
    localparam int REC_RESET     = 6;

    logic               clk;
    logic               rst;
    logic               dnpc_valid_i;
    logic               block_i;
    logic [XLEN-1:0]    dnpc_i;
    logic [XLEN-1:0]    pc_o;
    logic [INSTR_W-1:0] instr_o;
    logic               instr_valid_o;
    logic               dp_req_i;
    mem_op_e            dp_op_i;
    logic [XLEN-1:0]    dp_addr_i;
    line_t              dp_wdata_i;
    line_t              dp_rdata_o;
    logic               dp_ready_o;

    logic [LINE_W-1:0]  records [MAX_WORDS];
    // reference copy of main memory, updated on every data port write
    line_t              model [MEM_LINES];
    // pc the fetch port was last redirected to, or the reset pc
    logic [XLEN-1:0]    last_pc;
    int                 errors;

    fetch_top #(
        .RESET_PC  (RESET_PC),
        .IC_SETS   (IC_SETS),
        .MEM_LINES (MEM_LINES)
    ) dut_i (
        .clk           (clk),
        .rst           (rst),
        .dnpc_valid_i  (dnpc_valid_i),
        .block_i       (block_i),
        .dnpc_i        (dnpc_i),
        .pc_o          (pc_o),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .dp_req_i      (dp_req_i),
        .dp_op_i       (dp_op_i),
        .dp_addr_i     (dp_addr_i),
        .dp_wdata_i    (dp_wdata_i),
        .dp_rdata_o    (dp_rdata_o),
        .dp_ready_o    (dp_ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // word pc[3:2] of the modelled line holding pc
    function automatic logic [INSTR_W-1:0] model_word(input logic [XLEN-1:0] pc);
        line_t l;
        l = model[pc[4 +: MA_W]];
        return l[int'(pc[3:2]) * INSTR_W +: INSTR_W];
    endfunction

    task automatic check_value(input string name, input line_t exp, input line_t act);
        assert (act === exp) else begin
            $display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_event(input string name, input bit ok, input string what);
        assert (ok) else begin
            $display("ERROR %s: %s", name, what);
            errors++;
        end
    endtask

    // new pc on the fetch port, optionally held back by block_i for some cycles
    task automatic redirect(input string name, input logic [XLEN-1:0] pc, input int stall);
        @(posedge clk);
        dnpc_valid_i <= 1'b1;
        dnpc_i       <= pc;
        block_i      <= (stall > 0);
        if (stall > 0) begin
            // pc frozen at the previous target and nothing delivered while blocked
            repeat (stall) begin
                @(negedge clk);
                check_value(name, line_t'(last_pc), line_t'(pc_o));
                check_event(name, !instr_valid_o, "instr_valid_o pulsed while block_i was high");
            end
            @(posedge clk);
            block_i <= 1'b0;
        end
        @(posedge clk);
        dnpc_valid_i <= 1'b0;
        last_pc = pc;
    endtask

    task automatic wait_instr(output logic [INSTR_W-1:0] word, output logic [XLEN-1:0] pc,
                              output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < TIMEOUT) begin
            @(negedge clk);
            if (instr_valid_o) begin
                word = instr_o;
                pc   = pc_o;
                ok   = 1'b1;
            end
            n++;
        end
    endtask

    // full fetch with its word and pc checked against the expectation
    task automatic fetch_and_check(input string name, input logic [XLEN-1:0] pc, input int stall,
                                   input logic [INSTR_W-1:0] exp);
        logic [INSTR_W-1:0] word;
        logic [XLEN-1:0]    got_pc;
        bit                 ok;
        redirect(name, pc, stall);
        wait_instr(word, got_pc, ok);
        check_event(name, ok, "instr_valid_o did not arrive before the timeout");
        if (ok) begin
            check_value(name, line_t'(exp), line_t'(word));
            check_value(name, line_t'(pc), line_t'(got_pc));
        end
    endtask

    // one data port access, request held until ready
    task automatic dp_access(input mem_op_e op, input logic [XLEN-1:0] addr, input line_t wdata,
                             output line_t rdata, output bit ok);
        int n;
        ok    = 1'b0;
        n     = 0;
        rdata = '0;
        @(posedge clk);
        dp_req_i   <= 1'b1;
        dp_op_i    <= op;
        dp_addr_i  <= addr;
        dp_wdata_i <= wdata;
        while (!ok && n < TIMEOUT) begin
            @(negedge clk);
            if (dp_ready_o) begin
                rdata = dp_rdata_o;
                ok    = 1'b1;
            end
            n++;
        end
        @(posedge clk);
        dp_req_i <= 1'b0;
    endtask

    initial begin
        int                 idx;
        int                 kind;
        int                 tests;
        int                 failed;
        int                 err_before;
        logic [XLEN-1:0]    arg;
        line_t              data;
        line_t              rline;
        logic [INSTR_W-1:0] word;
        logic [XLEN-1:0]    got_pc;
        bit                 ok;
        string              name;

        rst          <= 1'b1;
        dnpc_valid_i <= 1'b0;
        // no fetch while the program is loaded
        block_i      <= 1'b1;
        dnpc_i       <= '0;
        dp_req_i     <= 1'b0;
        dp_op_i      <= MEM_READ;
        dp_addr_i    <= '0;
        dp_wdata_i   <= '0;
        errors  = 0;
        tests   = 0;
        failed  = 0;
        last_pc = RESET_PC;
        for (idx = 0; idx < MAX_WORDS; idx++) begin
            records[idx] = '0;
        end
        for (idx = 0; idx < MEM_LINES; idx++) begin
            model[idx] = '0;
        end
        $readmemh("tests/fetch_testdata.txt", records);

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        idx  = 0;
        kind = int'(records[0][7:0]);
        while (kind != REC_END && idx + 2 < MAX_WORDS) begin
            arg        = records[idx+1][XLEN-1:0];
            data       = records[idx+2];
            err_before = errors;
            case (kind)
                REC_WRITE: begin
                    name = $sformatf("write %h", arg);
                    model[arg[4 +: MA_W]] = data;
                    dp_access(MEM_WRITE, arg, data, rline, ok);
                    check_event(name, ok, "dp_ready_o did not arrive before the timeout");
                end
                REC_RESET: begin
                    // second reset, memory contents must survive it
                    name = "reset and first fetch";
                    check_event(name, data[INSTR_W-1:0] == model_word(RESET_PC),
                                "testdata word disagrees with the memory model");
                    @(posedge clk);
                    rst     <= 1'b1;
                    block_i <= 1'b0;
                    repeat (5) @(posedge clk);
                    rst <= 1'b0;
                    last_pc = RESET_PC;
                    @(negedge clk);
                    check_value(name, line_t'(RESET_PC), line_t'(pc_o));
                    check_event(name, !instr_valid_o, "instr_valid_o high right after reset");
                    check_event(name, !dp_ready_o, "dp_ready_o high right after reset");
                    wait_instr(word, got_pc, ok);
                    check_event(name, ok, "first fetch did not finish before the timeout");
                    if (ok) begin
                        check_value(name, line_t'(data[INSTR_W-1:0]), line_t'(word));
                        check_value(name, line_t'(RESET_PC), line_t'(got_pc));
                    end
                end
                REC_FETCH: begin
                    name = $sformatf("fetch %h", arg);
                    check_event(name, data[INSTR_W-1:0] == model_word(arg),
                                "testdata word disagrees with the memory model");
                    fetch_and_check(name, arg, 0, data[INSTR_W-1:0]);
                end
                REC_STALL: begin
                    name = $sformatf("stalled fetch %h", arg);
                    fetch_and_check(name, arg, int'(data[31:0]), model_word(arg));
                end
                REC_READ: begin
                    name = $sformatf("read %h", arg);
                    check_event(name, data == model[arg[4 +: MA_W]],
                                "testdata line disagrees with the memory model");
                    dp_access(MEM_READ, arg, '0, rline, ok);
                    check_event(name, ok, "dp_ready_o did not arrive before the timeout");
                    if (ok) begin
                        check_value(name, data, rline);
                    end
                end
                REC_MISS_READ: begin
                    name = $sformatf("fetch %h with read %h", arg, data[XLEN-1:0]);
                    fork
                        fetch_and_check(name, arg, 0, model_word(arg));
                        begin
                            // lands while the refill owns the memory
                            repeat (3) @(posedge clk);
                            dp_access(MEM_READ, data[XLEN-1:0], '0, rline, ok);
                            check_event(name, ok, "dp_ready_o did not arrive before the timeout");
                            if (ok) begin
                                check_value(name, model[data[4 +: MA_W]], rline);
                            end
                        end
                    join
                end
                default: begin
                    name = $sformatf("record %0d", idx / 3);
                    check_event(name, 1'b0, "unknown record kind in the testdata file");
                end
            endcase
            tests++;
            if (errors == err_before) begin
                $display("PASS %s", name);
            end else begin
                $display("FAIL %s", name);
                failed++;
            end
            idx += 3;
            kind = (idx < MAX_WORDS) ? int'(records[idx][7:0]) : REC_END;
        end

        $display("tests run: %0d, failed: %0d, errors: %0d", tests, failed, errors);
        if (errors == 0 && tests > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
